// File: test/dino_testdata.txt
# opcode then operands: write <address> <data> | run <cycles> | replay
# expect_go <bit> | expect_score <decimal> | check_sync
expect_go 0
expect_score 00000
write 1 0
run 100
expect_score 00012
expect_go 0
write 0 1200
write 1 248
run 200
expect_go 1
write 1 0
replay
run 900
expect_go 0
run 20000
write 0 100
write 1 248
run 30000
expect_go 1
check_sync

// File: build.f
+incdir+include
source/game_pkg.sv
source/video_pkg.sv
source/vga_timing.sv
source/obstacle_field.sv
source/score_counter.sv
source/pixel_renderer.sv
source/dino_game_top.sv
test/dino_game_assertions.sv
test/dino_game_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dino_game_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/dino_game_tb.sv
// Testbench for the runner game top with a cycle reference model
// Commands and expected values come from the test data file
`timescale 1ns/1ns
`default_nettype none

module dino_game_tb
    import game_pkg::*, video_pkg::*;
;
    localparam int MOTION_PERIOD = 8;
    localparam int SYNC_ALLOWANCE = 4 * 1600 + 1600 * 525;

    logic        clk;
    logic        reset;
    logic        write;
    logic        replay;
    logic [8:0]  address;
    logic [31:0] writedata;
    color_t      vga_r;
    color_t      vga_g;
    color_t      vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;
    logic        game_over;
    logic [19:0] score_digits;

    // Reference model state
    int          m_timer;
    int          m_speed;
    int          m_pass;
    int          m_cx;
    int          m_gx;
    int          m_lx;
    int          m_px;
    int          m_dx;
    int          m_dy;
    int          m_score;
    bit          m_go;
    logic [5:0]  m_lfsr;
    int          m_h;
    int          m_v;
    logic [23:0] exp_rgb;
    bit          exp_digit;
    bit          rgb_valid;
    int          edge_count;

    int    errors;
    int    checks;
    int    cycles;
    int    limit;
    int    target;
    string ops[$];
    int    arg_a[$];
    int    arg_b[$];

    dino_game_top #(
        .MOTION_PERIOD (MOTION_PERIOD)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .write        (write),
        .replay       (replay),
        .address      (address),
        .writedata    (writedata),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b),
        .vga_clk      (vga_clk),
        .vga_hs       (vga_hs),
        .vga_vs       (vga_vs),
        .vga_blank_n  (vga_blank_n),
        .vga_sync_n   (vga_sync_n),
        .game_over    (game_over),
        .score_digits (score_digits)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic bit box_overlap(input int ax, ay, bx, by, bw);
        return (ax < bx + bw) && (ax + 32 > bx) && (ay < by + 32) && (ay + 32 > by);
    endfunction

    function automatic bit in_rect(input int x, y, bx, by, bw, bh);
        return (x >= bx) && (x < bx + bw) && (y >= by) && (y < by + bh);
    endfunction

    // Active low inside the sync interval
    function automatic bit sync_level(input int count, start, width);
        return !((count >= start) && (count < start + width));
    endfunction

    // Respawn lands on an 11-bit coordinate
    function automatic int step_x(input int x, speed, offset);
        return (x <= speed) ? (int'(H_ACTIVE) + offset) % 2048 : x - speed;
    endfunction

    function automatic logic [19:0] to_bcd(input int value);
        logic [19:0] digits;
        int          v;
        v = value;
        for (int i = 0; i < 5; i++) begin
            digits[4*i +: 4] = 4'(v % 10);
            v = v / 10;
        end
        return digits;
    endfunction

    // Cells where a score glyph may cover the scene
    function automatic bit score_cell(input int h, input int v);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (in_rect(h, v, 120 + 16 * i, 10, 8, 8)) hit = 1'b1;
        end
        return hit;
    endfunction

    // Scene color at one raster position, digits left out
    function automatic logic [23:0] scene_color(input int h, input int v);
        logic [23:0] color;
        if (v < int'(HORIZON_Y)) begin
            color = SKY_RGB;
        end else if (v > int'(STRIPE_Y)) begin
            color = STRIPE_RGB;
        end else begin
            color = GROUND_RGB;
        end
        if (v == int'(HORIZON_Y)) begin
            color = LINE_RGB;
        end
        if (m_go) begin
            if (in_rect(h, v, 560, 200, 160, 32)) color = BANNER_RGB;
        end else begin
            if (in_rect(h, v, m_cx, 248, 32, 32)) color = CACTUS_RGB;
            if (in_rect(h, v, m_gx, 248, 64, 32)) color = GROUP_RGB;
            if (in_rect(h, v, m_lx, 248, 32, 32)) color = LAVA_RGB;
            if (in_rect(h, v, m_px, 200, 32, 32)) color = PTERO_RGB;
            if (in_rect(h, v, m_dx, m_dy, 32, 32)) color = DINO_RGB;
        end
        return color;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_write(input int addr, input int data);
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        write     <= 1'b1;
        address   <= 9'(addr);
        writedata <= 32'(data);
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic pulse_replay();
        repeat ($urandom % 4) @(posedge clk);
        @(posedge clk);
        replay <= 1'b1;
        @(posedge clk);
        replay <= 1'b0;
    endtask

    task automatic run_until(input int edges);
        while (edge_count < edges) @(negedge clk);
    endtask

    task automatic find_hs_fall(output int waited);
        logic prev;
        prev = vga_hs;
        @(negedge clk);
        waited = 1;
        while (!(prev === 1'b1 && vga_hs === 1'b0)) begin
            prev = vga_hs;
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic check_hs_timing();
        int waited;
        int low_len;
        int start_h;
        find_hs_fall(waited);
        start_h = int'(dut.u_timing.hcount);
        low_len = 0;
        while (vga_hs === 1'b0) begin
            low_len++;
            @(negedge clk);
        end
        find_hs_fall(waited);
        compare_value("vga_hs start", int'(H_ACTIVE + H_FRONT), start_h);
        compare_value("vga_hs low width", int'(H_SYNC), low_len);
        compare_value("vga_hs period", int'(H_TOTAL), low_len + waited);
    endtask

    // Model steps on the same edges as the DUT
    always @(posedge clk) begin
        bit tick;
        bit hit;
        bit wrapped;
        bit go_old;
        if (reset) begin
            m_timer = 0;
            m_speed = 1;
            m_pass = 0;
            m_cx = 1200;
            m_gx = 1600;
            m_lx = 1800;
            m_px = 1400;
            m_dx = 100;
            m_dy = 248;
            m_score = 0;
            m_go = 1'b0;
            m_lfsr = 6'b101011;
            m_h = 0;
            m_v = 0;
            rgb_valid = 1'b0;
            edge_count = 0;
        end else begin
            // Registered pixel follows the state before this edge
            exp_rgb = scene_color(m_h, m_v);
            exp_digit = !m_go && score_cell(m_h, m_v);
            rgb_valid = 1'b1;
            go_old = m_go;
            tick = !go_old && (m_timer == MOTION_PERIOD - 1);
            hit = box_overlap(m_dx, m_dy, m_cx, 248, 32) ||
                  box_overlap(m_dx, m_dy, m_gx, 248, 64) ||
                  box_overlap(m_dx, m_dy, m_lx, 248, 32) ||
                  box_overlap(m_dx, m_dy, m_px, 200, 32);
            if (go_old) begin
                if (replay) begin
                    m_cx = 1200;
                    m_gx = 1600;
                    m_lx = 1800;
                    m_px = 1400;
                    m_speed = 1;
                    m_pass = 0;
                    m_go = 1'b0;
                end
            end else begin
                if (tick) begin
                    wrapped = (m_cx <= m_speed) || (m_gx <= m_speed) ||
                              (m_lx <= m_speed) || (m_px <= m_speed);
                    m_cx = step_x(m_cx, m_speed, int'(m_lfsr) * 16);
                    m_gx = step_x(m_gx, m_speed, (63 - int'(m_lfsr)) * 16);
                    m_lx = step_x(m_lx, m_speed, int'(m_lfsr[3:0]) * 64);
                    m_px = step_x(m_px, m_speed, int'(m_lfsr[5:2]) * 64);
                    if (m_pass >= PASS_LIMIT) begin
                        m_speed++;
                        m_pass = 0;
                    end else if (wrapped) begin
                        m_pass++;
                    end
                    m_lfsr = {m_lfsr[4:0], m_lfsr[5] ^ m_lfsr[4]};
                    m_score = (m_score + 1) % 100000;
                end
                m_go = hit;
            end
            if (tick) begin
                m_timer = 0;
            end else if (!go_old) begin
                m_timer++;
            end
            if (write && address == 9'd0) m_dx = int'(writedata[10:0]);
            if (write && address == 9'd1) m_dy = int'(writedata[10:0]);
            if (m_h == int'(H_TOTAL) - 1) begin
                m_h = 0;
                m_v = (m_v == int'(V_TOTAL) - 1) ? 0 : m_v + 1;
            end else begin
                m_h++;
            end
            edge_count++;
        end
    end

    // Every cycle against the model
    always @(negedge clk) begin
        logic [23:0] rgb;
        if (!reset) begin
            compare_value("game_over", int'(m_go), int'(game_over));
            compare_value("score_digits", int'(to_bcd(m_score)), int'(score_digits));
            compare_value("vga_hs", int'(sync_level(m_h, int'(H_ACTIVE + H_FRONT),
                                                    int'(H_SYNC))), int'(vga_hs));
            compare_value("vga_vs", int'(sync_level(m_v, int'(V_ACTIVE + V_FRONT),
                                                    int'(V_SYNC))), int'(vga_vs));
            compare_value("vga_blank_n", int'(m_h < int'(H_ACTIVE) && m_v < int'(V_ACTIVE)),
                          int'(vga_blank_n));
            compare_value("vga_clk", m_h % 2, int'(vga_clk));
            compare_value("vga_sync_n", 0, int'(vga_sync_n));
            rgb = {vga_r, vga_g, vga_b};
            // A glyph pixel inside a score cell is also accepted
            if (rgb_valid && !(exp_digit && rgb == DIGIT_RGB)) begin
                compare_value("vga_r", int'(exp_rgb[23:16]), int'(vga_r));
                compare_value("vga_g", int'(exp_rgb[15:8]), int'(vga_g));
                compare_value("vga_b", int'(exp_rgb[7:0]), int'(vga_b));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        string line;
        string op;
        reset = 1'b1;
        write = 1'b0;
        replay = 1'b0;
        address = '0;
        writedata = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        limit = 0;
        target = 0;
        void'($urandom(63));

        fd = $fopen("test/dino_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                a = 0;
                b = 0;
                n = $sscanf(line, "%s %d %d", op, a, b);
                if (n >= 1 && op.getc(0) != "#") begin
                    ops.push_back(op);
                    arg_a.push_back(a);
                    arg_b.push_back(b);
                end
            end
            $fclose(fd);
        end

        // Limit from the run lengths in the data
        limit = 2000;
        foreach (ops[i]) begin
            if (ops[i] == "run") limit += arg_a[i];
            if (ops[i] == "check_sync") limit += SYNC_ALLOWANCE;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        foreach (ops[i]) begin
            case (ops[i])
                "write": drive_write(arg_a[i], arg_b[i]);
                "replay": pulse_replay();
                "run": begin
                    target += arg_a[i];
                    run_until(target);
                end
                "expect_go": compare_value("game_over", arg_a[i], int'(game_over));
                "expect_score": begin
                    compare_value("score_digits", int'(to_bcd(arg_a[i])), int'(score_digits));
                end
                "check_sync": begin
                    check_hs_timing();
                    // One whole field so vsync and vertical blanking are seen
                    run_until(edge_count + int'(H_TOTAL) * int'(V_TOTAL));
                    target = edge_count;
                end
                default: begin
                    errors++;
                    $display("Unknown command in the test data: %s", ops[i]);
                end
            endcase
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: test/dino_game_assertions.sv
// Concurrent checks on hsync width, game-over latching and score hold
`timescale 1ns/1ns
`default_nettype none

module dino_game_assertions
    import video_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        replay,
    input logic        vga_hs,
    input logic        game_over,
    input logic [19:0] score_digits
);
    logic [11:0] low_run;

    // Length of the current low stretch of hsync
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            low_run <= '0;
        end else if (!vga_hs) begin
            low_run <= low_run + 12'd1;
        end else begin
            low_run <= '0;
        end
    end

    hs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hs) |-> low_run == 12'(H_SYNC))
        else $error("hsync low width wrong");

    go_hold: assert property (@(posedge clk) disable iff (reset)
        $fell(game_over) |-> $past(replay))
        else $error("game_over fell without replay");

    score_hold: assert property (@(posedge clk) disable iff (reset)
        $past(game_over) |-> $stable(score_digits))
        else $error("score changed during game over");
endmodule

bind dino_game_top dino_game_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .replay       (replay),
    .vga_hs       (vga_hs),
    .game_over    (game_over),
    .score_digits (score_digits)
);

`default_nettype wire

// File: source/dino_game_top.sv
// Game top: dino position registers behind the host write port
// and the timing, obstacle, score and renderer blocks
`timescale 1ns/1ns
`default_nettype none

module dino_game_top
    import game_pkg::*, video_pkg::*;
#(
    parameter int MOTION_PERIOD = 2_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write,
    input  logic                  replay,
    input  logic [8:0]            address,
    input  logic [31:0]           writedata,
    output color_t                vga_r,
    output color_t                vga_g,
    output color_t                vga_b,
    output logic                  vga_clk,
    output logic                  vga_hs,
    output logic                  vga_vs,
    output logic                  vga_blank_n,
    output logic                  vga_sync_n,
    output logic                  game_over,
    output logic [4*N_DIGITS-1:0] score_digits
);
    hcount_t hcount;
    vcount_t vcount;
    coord_t  dino_x;
    coord_t  dino_y;
    coord_t  cactus_x;
    coord_t  group_x;
    coord_t  lava_x;
    coord_t  ptero_x;
    logic    motion_tick;

    // Address 0 is dino x, address 1 is dino y
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x <= DINO_X0;
            dino_y <= DINO_Y0;
        end else if (write) begin
            case (address)
                9'd0:    dino_x <= writedata[10:0];
                9'd1:    dino_y <= writedata[10:0];
                default: ;
            endcase
        end
    end

    vga_timing u_timing (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .vga_clk     (vga_clk),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

    obstacle_field #(
        .MOTION_PERIOD (MOTION_PERIOD)
    ) u_field (
        .clk         (clk),
        .reset       (reset),
        .replay      (replay),
        .dino_x      (dino_x),
        .dino_y      (dino_y),
        .cactus_x    (cactus_x),
        .group_x     (group_x),
        .lava_x      (lava_x),
        .ptero_x     (ptero_x),
        .game_over   (game_over),
        .motion_tick (motion_tick)
    );

    score_counter u_score (
        .clk          (clk),
        .reset        (reset),
        .motion_tick  (motion_tick),
        .score_digits (score_digits)
    );

    pixel_renderer u_render (
        .clk          (clk),
        .hcount       (hcount),
        .vcount       (vcount),
        .dino_x       (dino_x),
        .dino_y       (dino_y),
        .cactus_x     (cactus_x),
        .group_x      (group_x),
        .lava_x       (lava_x),
        .ptero_x      (ptero_x),
        .game_over    (game_over),
        .score_digits (score_digits),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );
endmodule

`default_nettype wire

// File: source/pixel_renderer.sv
// Per-pixel scene composition: ground, obstacles, dino, score, banner
`timescale 1ns/1ns
`default_nettype none

module pixel_renderer
    import game_pkg::*, video_pkg::*;
(
    input  logic                  clk,
    input  hcount_t               hcount,
    input  vcount_t               vcount,
    input  coord_t                dino_x,
    input  coord_t                dino_y,
    input  coord_t                cactus_x,
    input  coord_t                group_x,
    input  coord_t                lava_x,
    input  coord_t                ptero_x,
    input  logic                  game_over,
    input  logic [4*N_DIGITS-1:0] score_digits,
    output color_t                vga_r,
    output color_t                vga_g,
    output color_t                vga_b
);
    `include "digit_font.svh"

    coord_t      px;
    coord_t      py;
    logic        digit_on;
    logic [23:0] pixel;

    function automatic logic in_box(input coord_t x, y, bx, by, bw, bh);
        return ({1'b0, x} >= {1'b0, bx}) && ({1'b0, x} < {1'b0, bx} + {1'b0, bw}) &&
               ({1'b0, y} >= {1'b0, by}) && ({1'b0, y} < {1'b0, by} + {1'b0, bh});
    endfunction

    function automatic logic glyph_bit(input bcd_digit_t digit, input coord_t row, col);
        return (digit <= 4'd9) && DIGIT_FONT[digit][row[2:0]][3'd7 - col[2:0]];
    endfunction

    assign px = hcount;
    assign py = coord_t'(vcount);

    // Most significant digit sits leftmost
    always_comb begin
        coord_t slot_x;
        digit_on = 1'b0;
        for (int i = 0; i < N_DIGITS; i++) begin
            slot_x = SCORE_X + coord_t'(i) * DIGIT_PITCH;
            if (in_box(px, py, slot_x, SCORE_Y, coord_t'(FONT_SIZE), coord_t'(FONT_SIZE)) &&
                glyph_bit(score_digits[4*(N_DIGITS-1-i) +: 4], py - SCORE_Y, px - slot_x)) begin
                digit_on = 1'b1;
            end
        end
    end

    // Later assignments draw on top
    always_comb begin
        if (vcount < HORIZON_Y) begin
            pixel = SKY_RGB;
        end else if (vcount > STRIPE_Y) begin
            pixel = STRIPE_RGB;
        end else begin
            pixel = GROUND_RGB;
        end
        if (vcount == HORIZON_Y) begin
            pixel = LINE_RGB;
        end
        if (!game_over) begin
            if (in_box(px, py, cactus_x, GROUND_Y, OBJ_SIZE, OBJ_SIZE)) pixel = CACTUS_RGB;
            if (in_box(px, py, group_x, GROUND_Y, GROUP_W, OBJ_SIZE)) pixel = GROUP_RGB;
            if (in_box(px, py, lava_x, GROUND_Y, OBJ_SIZE, OBJ_SIZE)) pixel = LAVA_RGB;
            if (in_box(px, py, ptero_x, PTERO_Y, OBJ_SIZE, OBJ_SIZE)) pixel = PTERO_RGB;
            if (in_box(px, py, dino_x, dino_y, OBJ_SIZE, OBJ_SIZE)) pixel = DINO_RGB;
            if (digit_on) pixel = DIGIT_RGB;
        end else if (in_box(px, py, BANNER_X, BANNER_Y, BANNER_W, OBJ_SIZE)) begin
            pixel = BANNER_RGB;
        end
    end

    always_ff @(posedge clk) begin
        {vga_r, vga_g, vga_b} <= pixel;
    end
endmodule

`default_nettype wire

// File: source/score_counter.sv
// Five-digit BCD score advanced once per motion tick
`timescale 1ns/1ns
`default_nettype none

module score_counter
    import game_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  motion_tick,
    output logic [4*N_DIGITS-1:0] score_digits
);
    logic [4*N_DIGITS-1:0] score_next;

    // Decimal ripple from the units digit up, 99999 rolls to zero
    always_comb begin
        bcd_digit_t digit;
        logic       carry;
        carry = 1'b1;
        for (int i = 0; i < N_DIGITS; i++) begin
            digit = score_digits[4*i +: 4];
            if (carry && digit == 4'd9) begin
                score_next[4*i +: 4] = 4'd0;
            end else begin
                score_next[4*i +: 4] = digit + {3'd0, carry};
                carry = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score_digits <= '0;
        end else if (motion_tick) begin
            score_digits <= score_next;
        end
    end
endmodule

`default_nettype wire

// File: source/obstacle_field.sv
// Obstacle motion with LFSR respawn, speed rule, dino collision
// and game-over state with replay
`timescale 1ns/1ns
`default_nettype none

module obstacle_field
    import game_pkg::*, video_pkg::*;
#(
    parameter int MOTION_PERIOD = 2_000_000
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   replay,
    input  coord_t dino_x,
    input  coord_t dino_y,
    output coord_t cactus_x,
    output coord_t group_x,
    output coord_t lava_x,
    output coord_t ptero_x,
    output logic   game_over,
    output logic   motion_tick
);
    localparam int TIMER_W = $clog2(MOTION_PERIOD + 1);

    logic [TIMER_W-1:0] motion_timer;
    logic [5:0]         lfsr;
    speed_t             speed;
    logic [4:0]         pass_count;
    logic               cactus_wrap;
    logic               group_wrap;
    logic               lava_wrap;
    logic               ptero_wrap;
    logic               overlap;

    // Dino box is OBJ_SIZE square, obstacle box is bw wide and OBJ_SIZE tall
    function automatic logic boxes_overlap(input coord_t ax, ay, bx, by, bw);
        logic [11:0] a_right;
        logic [11:0] a_bottom;
        logic [11:0] b_right;
        logic [11:0] b_bottom;
        a_right  = {1'b0, ax} + {1'b0, OBJ_SIZE};
        a_bottom = {1'b0, ay} + {1'b0, OBJ_SIZE};
        b_right  = {1'b0, bx} + {1'b0, bw};
        b_bottom = {1'b0, by} + {1'b0, OBJ_SIZE};
        return ({1'b0, ax} < b_right) && (a_right > {1'b0, bx}) &&
               ({1'b0, ay} < b_bottom) && (a_bottom > {1'b0, by});
    endfunction

    assign motion_tick = !game_over && (motion_timer == TIMER_W'(MOTION_PERIOD - 1));

    assign cactus_wrap = (cactus_x <= speed);
    assign group_wrap  = (group_x <= speed);
    assign lava_wrap   = (lava_x <= speed);
    assign ptero_wrap  = (ptero_x <= speed);

    assign overlap = boxes_overlap(dino_x, dino_y, cactus_x, GROUND_Y, OBJ_SIZE) ||
                     boxes_overlap(dino_x, dino_y, group_x, GROUND_Y, GROUP_W) ||
                     boxes_overlap(dino_x, dino_y, lava_x, GROUND_Y, OBJ_SIZE) ||
                     boxes_overlap(dino_x, dino_y, ptero_x, PTERO_Y, OBJ_SIZE);

    // Timer freezes while the game is over
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            motion_timer <= '0;
        end else if (motion_tick) begin
            motion_timer <= '0;
        end else if (!game_over) begin
            motion_timer <= motion_timer + 1'b1;
        end
    end

    // x^6 + x^5 + 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (motion_tick) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cactus_x   <= CACTUS_START;
            group_x    <= GROUP_START;
            lava_x     <= LAVA_START;
            ptero_x    <= PTERO_START;
            speed      <= SPEED_INIT;
            pass_count <= '0;
            game_over  <= 1'b0;
        end else if (game_over) begin
            if (replay) begin
                cactus_x   <= CACTUS_START;
                group_x    <= GROUP_START;
                lava_x     <= LAVA_START;
                ptero_x    <= PTERO_START;
                speed      <= SPEED_INIT;
                pass_count <= '0;
                game_over  <= 1'b0;
            end
        end else begin
            game_over <= overlap;
            if (motion_tick) begin
                // Respawn past the right edge, offset differs per obstacle
                cactus_x <= cactus_wrap ? H_ACTIVE + coord_t'({lfsr, 4'd0})
                                        : cactus_x - speed;
                group_x  <= group_wrap ? H_ACTIVE + coord_t'({~lfsr, 4'd0})
                                       : group_x - speed;
                lava_x   <= lava_wrap ? H_ACTIVE + coord_t'({lfsr[3:0], 6'd0})
                                      : lava_x - speed;
                ptero_x  <= ptero_wrap ? H_ACTIVE + coord_t'({lfsr[5:2], 6'd0})
                                       : ptero_x - speed;
                if (cactus_wrap || group_wrap || lava_wrap || ptero_wrap) begin
                    pass_count <= pass_count + 1'b1;
                end
                // Speed-up wins over the pass increment
                if (pass_count >= 5'(PASS_LIMIT)) begin
                    speed      <= speed + 1'b1;
                    pass_count <= '0;
                end
            end
        end
    end
endmodule

`default_nettype wire

// File: source/vga_timing.sv
// Raster counters with sync, blank and pixel clock outputs
`timescale 1ns/1ns
`default_nettype none

module vga_timing
    import video_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    vga_clk,
    output logic    vga_hs,
    output logic    vga_vs,
    output logic    vga_blank_n,
    output logic    vga_sync_n
);
    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (hcount == H_TOTAL - 11'd1);
    assign end_of_field = (vcount == V_TOTAL - 10'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            hcount <= end_of_line ? '0 : hcount + 11'd1;
            // Line count moves only on the last pixel of a line
            if (end_of_line) begin
                vcount <= end_of_field ? '0 : vcount + 10'd1;
            end
        end
    end

    // Active low sync inside each sync interval
    assign vga_hs = !((hcount >= H_ACTIVE + H_FRONT) &&
                      (hcount < H_ACTIVE + H_FRONT + H_SYNC));
    assign vga_vs = !((vcount >= V_ACTIVE + V_FRONT) &&
                      (vcount < V_ACTIVE + V_FRONT + V_SYNC));

    assign vga_blank_n = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];
endmodule

`default_nettype wire

// File: source/video_pkg.sv
// VGA timing constants, counter and color types, scene colors
`default_nettype none

package video_pkg;
    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [7:0]  color_t;

    // 1280x480 line timing
    localparam hcount_t H_ACTIVE = 11'd1280;
    localparam hcount_t H_FRONT  = 11'd32;
    localparam hcount_t H_SYNC   = 11'd192;
    localparam hcount_t H_BACK   = 11'd96;
    localparam hcount_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Field timing
    localparam vcount_t V_ACTIVE = 10'd480;
    localparam vcount_t V_FRONT  = 10'd10;
    localparam vcount_t V_SYNC   = 10'd2;
    localparam vcount_t V_BACK   = 10'd33;
    localparam vcount_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam vcount_t HORIZON_Y = 10'd280;
    localparam vcount_t STRIPE_Y  = 10'd300;

    // Scene colors, packed R then G then B
    localparam logic [23:0] SKY_RGB    = 24'h87CEEB;
    localparam logic [23:0] GROUND_RGB = 24'h8B4513;
    localparam logic [23:0] STRIPE_RGB = 24'h64280A;
    localparam logic [23:0] LINE_RGB   = 24'h000000;
    localparam logic [23:0] CACTUS_RGB = 24'h228B22;
    localparam logic [23:0] GROUP_RGB  = 24'h006400;
    localparam logic [23:0] LAVA_RGB   = 24'hFF4500;
    localparam logic [23:0] PTERO_RGB  = 24'h707070;
    localparam logic [23:0] DINO_RGB   = 24'h535353;
    localparam logic [23:0] BANNER_RGB = 24'hF0F0F0;
    localparam logic [23:0] DIGIT_RGB  = 24'h000000;
endpackage

`default_nettype wire

// File: source/game_pkg.sv
// Playfield geometry, obstacle placement and speed rule constants
// Coordinate, speed and score digit types
`default_nettype none

package game_pkg;
    typedef logic [10:0] coord_t;
    typedef logic [10:0] speed_t;
    typedef logic [3:0]  bcd_digit_t;

    localparam int N_DIGITS = 5;

    // Box sizes, all objects are OBJ_SIZE tall
    localparam coord_t OBJ_SIZE = 11'd32;
    localparam coord_t GROUP_W  = 11'd64;

    // Obstacle rows and start columns
    localparam coord_t GROUND_Y     = 11'd248;
    localparam coord_t PTERO_Y      = 11'd200;
    localparam coord_t CACTUS_START = 11'd1200;
    localparam coord_t PTERO_START  = 11'd1400;
    localparam coord_t GROUP_START  = 11'd1600;
    localparam coord_t LAVA_START   = 11'd1800;

    localparam coord_t DINO_X0 = 11'd100;
    localparam coord_t DINO_Y0 = 11'd248;

    // Speed rule
    localparam int         PASS_LIMIT = 12;
    localparam speed_t     SPEED_INIT = 11'd1;
    localparam logic [5:0] LFSR_SEED  = 6'b101011;

    // Score and banner placement
    localparam coord_t SCORE_X     = 11'd120;
    localparam coord_t SCORE_Y     = 11'd10;
    localparam coord_t DIGIT_PITCH = 11'd16;
    localparam coord_t BANNER_X    = 11'd560;
    localparam coord_t BANNER_Y    = 11'd200;
    localparam coord_t BANNER_W    = 11'd160;
endpackage

`default_nettype wire

// File: include/digit_font.svh
// 8x8 bitmaps for the decimal digits, bit 7 is the leftmost column
`ifndef DIGIT_FONT_SVH
`define DIGIT_FONT_SVH

localparam int FONT_SIZE = 8;

localparam logic [7:0] DIGIT_FONT [0:9][0:7] = '{
    '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
    '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
    '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
    '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
};

`endif
